// File: ow_pkg.sv
////////////////////////////////////////
// shared constants for the 1-wire EPROM reader
// timing in microseconds, scaled by clk_mhz in the slot timer
////////////////////////////////////////
package ow_pkg;

    ////////////////////////////////////////
    // 1-wire timing, microseconds
    localparam int reset_low_us        = 480;  // master reset pulse
    localparam int rise_timeout_us     = 5;    // line must float high within this
    localparam int ack_wait_us         = 30;   // inside the 15..60 us presence window
    localparam int presence_timeout_us = 300;
    localparam int recover_us          = 500;  // line high before first command
    localparam int write_slot_us       = 90;   // slot plus recovery
    localparam int write0_low_us       = 80;
    localparam int write1_low_us       = 8;
    localparam int read_low_us         = 1;
    localparam int read_sample_us      = 15;
    localparam int read_slot_us        = 121;

    // device commands
    localparam logic [7:0] cmd_skip_rom    = 8'hCC;
    localparam logic [7:0] cmd_read_memory = 8'hF0;

    // host control codes, status/control word bits 1:0
    localparam logic [1:0] ctl_disable  = 2'd0;  // release the line
    localparam logic [1:0] ctl_enable   = 2'd1;  // take the line
    localparam logic [1:0] ctl_start    = 2'd2;  // read from address in bits 26:16
    localparam logic [1:0] ctl_continue = 2'd3;  // next block

    localparam logic [15:0] reg_dsstat_addr = 16'h0009;
    localparam int          block_bytes     = 64;

    // slot kinds
    localparam logic [1:0] slot_reset = 2'd0;
    localparam logic [1:0] slot_write = 2'd1;
    localparam logic [1:0] slot_read  = 2'd2;

    // reset results
    localparam logic [1:0] rst_none        = 2'd0;  // not attempted yet
    localparam logic [1:0] rst_ok          = 2'd1;
    localparam logic [1:0] rst_no_rise     = 2'd2;  // line stayed low, pull-up missing?
    localparam logic [1:0] rst_no_presence = 2'd3;  // nobody answered

    ////////////////////////////////////////
    // status word layout
    localparam int stat_result_lsb = 0;   // 2 bits
    localparam int stat_busy_bit   = 2;
    localparam int stat_enable_bit = 3;
    localparam int stat_rise_lsb   = 8;   // 8 bits
    localparam int stat_addr_lsb   = 16;  // 11 bits

endpackage

// File: ow_slot_timer.sv
////////////////////////////////////////
// 1-wire line timing: reset/presence, write and read slots
////////////////////////////////////////
`timescale 1ns/10ps

module ow_slot_timer #(
    parameter int clk_mhz = 49
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       slot_start,
    input  logic [1:0] slot_kind,
    input  logic       tx_bit,
    input  logic       ds_data_in,
    output logic       slot_done,
    output logic       rx_bit,
    output logic [1:0] reset_result,
    output logic [7:0] rise_cycles,
    output logic       ds_dir,
    output logic       ds_data_out
);
    import ow_pkg::*;

    localparam int cnt_w = 20;

    // counts in clocks, cnt reads k at the k-th edge after start
    localparam logic [cnt_w-1:0] reset_cnt    = cnt_w'(reset_low_us * clk_mhz);
    localparam logic [cnt_w-1:0] rise_cnt     = cnt_w'(rise_timeout_us * clk_mhz);
    localparam logic [cnt_w-1:0] ack_cnt      = cnt_w'(ack_wait_us * clk_mhz);
    localparam logic [cnt_w-1:0] presence_cnt = cnt_w'(presence_timeout_us * clk_mhz);
    localparam logic [cnt_w-1:0] recover_cnt  = cnt_w'(recover_us * clk_mhz);
    localparam logic [cnt_w-1:0] w0_cnt       = cnt_w'(write0_low_us * clk_mhz);
    localparam logic [cnt_w-1:0] w1_cnt       = cnt_w'(write1_low_us * clk_mhz);
    localparam logic [cnt_w-1:0] wdone_cnt    = cnt_w'(write_slot_us * clk_mhz - 1);
    localparam logic [cnt_w-1:0] rlow_cnt     = cnt_w'(read_low_us * clk_mhz);
    localparam logic [cnt_w-1:0] rsample_cnt  = cnt_w'(read_sample_us * clk_mhz);
    localparam logic [cnt_w-1:0] rdone_cnt    = cnt_w'(read_slot_us * clk_mhz - 1);

    localparam logic [2:0] ph_idle      = 3'd0;
    localparam logic [2:0] ph_reset_low = 3'd1;
    localparam logic [2:0] ph_rise      = 3'd2;
    localparam logic [2:0] ph_ack_wait  = 3'd3;
    localparam logic [2:0] ph_presence  = 3'd4;
    localparam logic [2:0] ph_recover   = 3'd5;
    localparam logic [2:0] ph_write     = 3'd6;
    localparam logic [2:0] ph_read      = 3'd7;

    logic [2:0]       phase;
    logic [cnt_w-1:0] cnt;
    logic             bit_q;      // bit being written
    logic             line_meta;
    logic             line_in;    // synchronized line level

    assign ds_data_out = ~ds_dir;  // only ever drive a low

    always_ff @(posedge clk) begin  // two-flop sync of the open-drain line
        line_meta <= ds_data_in;
        line_in   <= line_meta;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= ph_idle;
            cnt          <= '0;
            bit_q        <= 1'b0;
            slot_done    <= 1'b0;
            rx_bit       <= 1'b1;
            reset_result <= rst_none;
            rise_cycles  <= 8'd0;
            ds_dir       <= 1'b0;
        end else begin
            slot_done <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (phase)
                ph_idle: begin
                    cnt <= cnt_w'(1);
                    if (slot_start) begin
                        ds_dir <= 1'b1;  // every kind opens with a low
                        bit_q  <= tx_bit;
                        case (slot_kind)
                            slot_reset: begin
                                phase        <= ph_reset_low;
                                reset_result <= rst_none;
                            end
                            slot_read: phase <= ph_read;
                            default:   phase <= ph_write;
                        endcase
                    end
                end
                ph_reset_low: if (cnt == reset_cnt) begin
                    ds_dir <= 1'b0;
                    phase  <= ph_rise;
                    cnt    <= '0;   // now counting rise time
                end
                ph_rise: begin
                    if (line_in) begin
                        rise_cycles <= (cnt > cnt_w'(255)) ? 8'hFF : cnt[7:0];
                        phase       <= ph_ack_wait;
                        cnt         <= cnt_w'(1);
                    end else if (cnt == rise_cnt) begin
                        rise_cycles  <= 8'hFF;
                        reset_result <= rst_no_rise;
                        slot_done    <= 1'b1;
                        phase        <= ph_idle;
                    end
                end
                ph_ack_wait: if (cnt == ack_cnt) begin
                    phase <= ph_presence;
                    cnt   <= cnt_w'(1);
                end
                ph_presence: begin
                    if (!line_in) begin  // device pulls low
                        reset_result <= rst_ok;
                        phase        <= ph_recover;
                        cnt          <= '0;
                    end else if (cnt == presence_cnt) begin
                        reset_result <= rst_no_presence;
                        slot_done    <= 1'b1;
                        phase        <= ph_idle;
                    end
                end
                ph_recover: begin
                    if (!line_in) begin
                        cnt <= '0;   // presence still on, restart
                    end else if (cnt == recover_cnt) begin
                        slot_done <= 1'b1;
                        phase     <= ph_idle;
                    end
                end
                ph_write: begin
                    if (cnt == (bit_q ? w1_cnt : w0_cnt))
                        ds_dir <= 1'b0;
                    if (cnt == wdone_cnt) begin
                        slot_done <= 1'b1;
                        phase     <= ph_idle;
                    end
                end
                default: begin  // read slot
                    if (cnt == rlow_cnt)
                        ds_dir <= 1'b0;
                    if (cnt == rsample_cnt)
                        rx_bit <= line_in;
                    if (cnt == rdone_cnt) begin
                        slot_done <= 1'b1;
                        phase     <= ph_idle;
                    end
                end
            endcase
        end
    end

endmodule

// File: ow_byte_engine.sv
////////////////////////////////////////
// one byte as eight 1-wire slots, LSB first
////////////////////////////////////////
`timescale 1ns/10ps

module ow_byte_engine (
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_start,
    input  logic       byte_read,
    input  logic [7:0] tx_byte,
    input  logic       slot_done,
    input  logic       rx_bit,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       slot_start,
    output logic       tx_bit
);

    logic       active;
    logic       launch;    // first slot, one cycle after byte_start
    logic [2:0] bit_cnt;
    logic [7:0] sr;        // tx bits out of bit 0, rx bits in at bit 7
    logic       last_bit;
    logic       step;

    assign last_bit = (bit_cnt == 3'd7);
    assign step     = active & slot_done;

    // next slot launches in the done cycle, so a byte is 8 slots + 1 clock
    assign slot_start = launch | (step & ~last_bit);
    assign byte_done  = step & last_bit;
    assign tx_bit     = step ? sr[1] : sr[0];  // sr shifts on this same edge
    assign rx_byte    = {rx_bit, sr[7:1]};     // last bit still in rx_bit

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            launch  <= 1'b0;
            bit_cnt <= 3'd0;
        end else begin
            launch <= 1'b0;
            if (byte_start && !active) begin
                active  <= 1'b1;
                launch  <= 1'b1;
                bit_cnt <= 3'd0;
            end else if (step) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (last_bit)
                    active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_start && !active)
            sr <= byte_read ? 8'hFF : tx_byte;  // a read slot writes a 1
        else if (step)
            sr <= {rx_bit, sr[7:1]};
    end

endmodule

// File: ow_read_sequencer.sv
////////////////////////////////////////
// read transaction: reset, CC, F0, address, 64 data bytes
////////////////////////////////////////
`timescale 1ns/10ps

module ow_read_sequencer (
    input  logic        clk,
    input  logic        reset,
    input  logic        txn_start,
    input  logic [10:0] mem_addr,
    input  logic        byte_done,
    input  logic [7:0]  rx_byte,
    input  logic        slot_done,
    input  logic [1:0]  reset_result,
    output logic        busy,
    output logic        txn_done,
    output logic        byte_start,
    output logic        byte_read,
    output logic [7:0]  tx_byte,
    output logic        slot_start_rst,
    output logic [1:0]  slot_kind,
    output logic        byte_we,
    output logic [7:0]  wr_byte,
    output logic [5:0]  byte_index
);
    import ow_pkg::*;

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_reset   = 3'd1;
    localparam logic [2:0] st_skip    = 3'd2;
    localparam logic [2:0] st_cmd     = 3'd3;
    localparam logic [2:0] st_addr_lo = 3'd4;
    localparam logic [2:0] st_addr_hi = 3'd5;
    localparam logic [2:0] st_data    = 3'd6;
    localparam logic [2:0] st_done    = 3'd7;

    logic [2:0] state;

    assign busy     = (state != st_idle);
    assign txn_done = (state == st_done);
    // reset kind while resetting, else follow the byte direction
    assign slot_kind = (state == st_reset) ? slot_reset :
                       (byte_read ? slot_read : slot_write);

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= st_idle;
            byte_start     <= 1'b0;
            byte_read      <= 1'b0;
            slot_start_rst <= 1'b0;
            byte_we        <= 1'b0;
            byte_index     <= 6'd0;
        end else begin
            byte_start     <= 1'b0;
            slot_start_rst <= 1'b0;
            byte_we        <= 1'b0;
            if (byte_we)
                byte_index <= byte_index + 6'd1;
            case (state)
                st_idle: if (txn_start) begin
                    state          <= st_reset;
                    slot_start_rst <= 1'b1;
                    byte_read      <= 1'b0;
                    byte_index     <= 6'd0;
                end
                st_reset: if (slot_done) begin
                    if (reset_result == rst_ok) begin
                        state      <= st_skip;
                        byte_start <= 1'b1;
                    end else begin
                        state <= st_done;   // abort, result already latched
                    end
                end
                st_skip:    if (byte_done) begin
                    state      <= st_cmd;
                    byte_start <= 1'b1;
                end
                st_cmd:     if (byte_done) begin
                    state      <= st_addr_lo;
                    byte_start <= 1'b1;
                end
                st_addr_lo: if (byte_done) begin
                    state      <= st_addr_hi;
                    byte_start <= 1'b1;
                end
                st_addr_hi: if (byte_done) begin
                    state      <= st_data;
                    byte_start <= 1'b1;
                    byte_read  <= 1'b1;
                end
                st_data: if (byte_done) begin
                    byte_we <= 1'b1;
                    if (byte_index == 6'(block_bytes - 1))
                        state <= st_done;
                    else
                        byte_start <= 1'b1;
                end
                default: begin  // st_done, one cycle
                    state     <= st_idle;
                    byte_read <= 1'b0;
                end
            endcase
        end
    end

    // outgoing byte picked from the state being left
    always_ff @(posedge clk) begin
        case (state)
            st_reset:   tx_byte <= cmd_skip_rom;
            st_skip:    tx_byte <= cmd_read_memory;
            st_cmd:     tx_byte <= mem_addr[7:0];
            st_addr_lo: tx_byte <= {5'd0, mem_addr[10:8]};
            default:    tx_byte <= 8'hFF;
        endcase
        if (state == st_data && byte_done)
            wr_byte <= rx_byte;
    end

endmodule

// File: ow_mem_buffer.sv
////////////////////////////////////////
// 64 read bytes packed into 16 quadlets, block read port
////////////////////////////////////////
`timescale 1ns/10ps

module ow_mem_buffer (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        byte_we,
    input  logic [5:0]  byte_index,
    input  logic [7:0]  wr_byte,
    input  logic [3:0]  rd_addr,
    output logic [31:0] rd_data
);
    import ow_pkg::*;

    localparam int n_quads = block_bytes / 4;

    logic [31:0] quad [n_quads];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int i = 0; i < n_quads; i++)
                quad[i] <= '0;
        end else if (byte_we) begin
            // shift up, so the first byte of four ends in 31:24
            quad[byte_index[5:2]] <= {quad[byte_index[5:2]][23:0], wr_byte};
        end
    end

    always_ff @(posedge clk)
        rd_data <= quad[rd_addr];  // one cycle after address

endmodule

// File: ow_host_regs.sv
////////////////////////////////////////
// status/control register, control decode and status word
////////////////////////////////////////
`timescale 1ns/10ps

module ow_host_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic        busy,
    input  logic        txn_done,
    input  logic [1:0]  reset_result,
    input  logic [7:0]  rise_cycles,
    output logic        txn_start,
    output logic [10:0] mem_addr,
    output logic        ds_enable,
    output logic [31:0] ds_status
);
    import ow_pkg::*;

    logic       ctl_wr;
    logic [1:0] ctl_code;
    logic [1:0] result_q;
    logic [7:0] rise_q;

    assign ctl_wr    = reg_wen && (reg_waddr == reg_dsstat_addr) && !busy;  // ignored while busy
    assign ctl_code  = reg_wdata[1:0];
    assign txn_start = ctl_wr && (ctl_code == ctl_start || ctl_code == ctl_continue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_enable <= 1'b0;
            mem_addr  <= 11'd0;
            result_q  <= rst_none;
            rise_q    <= 8'd0;
        end else begin
            if (ctl_wr) begin
                case (ctl_code)
                    ctl_disable: ds_enable <= 1'b0;
                    ctl_enable:  ds_enable <= 1'b1;
                    ctl_start: begin
                        ds_enable <= 1'b1;
                        mem_addr  <= reg_wdata[26:16];
                    end
                    default: mem_addr <= mem_addr + 11'(block_bytes);  // wraps at 2K
                endcase
            end
            if (txn_start) begin
                result_q <= rst_none;
                rise_q   <= 8'd0;
            end else if (txn_done) begin
                result_q <= reset_result;
                rise_q   <= rise_cycles;
            end
        end
    end

    always_comb begin
        ds_status = '0;
        ds_status[stat_result_lsb +: 2] = result_q;
        ds_status[stat_busy_bit]        = busy;
        ds_status[stat_enable_bit]      = ds_enable;
        ds_status[stat_rise_lsb +: 8]   = rise_q;
        ds_status[stat_addr_lsb +: 11]  = mem_addr;
    end

endmodule

// File: ds2505_reader.sv
////////////////////////////////////////
// DS2505 1-wire EPROM reader, direct line drive
// host writes the control word, reads 16 quadlets by block address
////////////////////////////////////////
`timescale 1ns/10ps

module ds2505_reader #(
    parameter int clk_mhz = 49
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    output logic [31:0] reg_rdata,
    input  logic [31:0] reg_wdata,
    output logic [31:0] ds_status,
    input  logic        reg_wen,
    input  logic        ds_data_in,
    output logic        ds_data_out,
    output logic        ds_dir,     // 1 while pulling the line low
    output logic        ds_enable
);

    logic        txn_start, txn_done, busy;
    logic [10:0] mem_addr;
    logic        byte_start, byte_read, byte_done;
    logic [7:0]  tx_byte, rx_byte;
    logic        slot_start, slot_start_rst, eng_slot_start;
    logic [1:0]  slot_kind;
    logic        slot_done, tx_bit, rx_bit;
    logic [1:0]  reset_result;
    logic [7:0]  rise_cycles;
    logic        byte_we;
    logic [7:0]  wr_byte;
    logic [5:0]  byte_index;

    assign slot_start = slot_start_rst | eng_slot_start;  // never both at once

    ow_host_regs regs0 (
        .clk, .reset, .reg_waddr, .reg_wdata, .reg_wen, .busy, .txn_done,
        .reset_result, .rise_cycles, .txn_start, .mem_addr, .ds_enable, .ds_status
    );

    ow_read_sequencer seq0 (
        .clk, .reset, .txn_start, .mem_addr, .byte_done, .rx_byte, .slot_done,
        .reset_result, .busy, .txn_done, .byte_start, .byte_read, .tx_byte,
        .slot_start_rst, .slot_kind, .byte_we, .wr_byte, .byte_index
    );

    ow_byte_engine eng0 (
        .clk, .reset, .byte_start, .byte_read, .tx_byte, .slot_done, .rx_bit,
        .byte_done, .rx_byte, .slot_start(eng_slot_start), .tx_bit
    );

    ow_slot_timer #(.clk_mhz(clk_mhz)) slot0 (
        .clk, .reset, .slot_start, .slot_kind, .tx_bit, .ds_data_in,
        .slot_done, .rx_bit, .reset_result, .rise_cycles, .ds_dir, .ds_data_out
    );

    ow_mem_buffer buf0 (
        .clk, .reset, .clear(txn_start), .byte_we, .byte_index, .wr_byte,
        .rd_addr(reg_raddr[3:0]), .rd_data(reg_rdata)
    );

endmodule

// File: tb_ds2505_model.sv
////////////////////////////////////////
// behavioral DS2505 slave on an open-drain 1-wire line
// serves address XOR 5A, counts wrong command bytes
////////////////////////////////////////
`timescale 1ns/10ps

module tb_ds2505_model #(
    parameter int clk_mhz = 1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        ds_dir,      // master pulls low
    input  logic        disconnect,  // device listens but never drives the line
    input  logic        stuck_low,   // line shorted to ground
    output logic        line,
    output int          wr_bytes,    // bytes written to the device
    output int          bad_cmds,    // command bytes that did not match
    output logic [10:0] seen_addr    // start address last received
);
    localparam int reset_min = 400 * clk_mhz;
    localparam int pres_wait = 15 * clk_mhz;
    localparam int pres_len  = 120 * clk_mhz;
    localparam int sample_at = 30 * clk_mhz;
    localparam int hold_len  = 30 * clk_mhz;

    localparam logic [2:0] m_idle      = 3'd0;
    localparam logic [2:0] m_pres_wait = 3'd1;
    localparam logic [2:0] m_pres_low  = 3'd2;
    localparam logic [2:0] m_wsample   = 3'd3;
    localparam logic [2:0] m_rhold     = 3'd4;

    logic [2:0]  mode;
    logic [2:0]  phase;      // 0 skip rom, 1 command, 2 addr lo, 3 addr hi, 4 data
    logic [2:0]  nbit;
    logic [7:0]  sr;
    logic [7:0]  sr_next;
    logic [10:0] addr;       // read pointer, auto increments
    logic [7:0]  data_byte;
    logic        pull;
    logic        line_q;
    int          low_cnt;
    int          tmr;

    // wired-AND with pull-up, a disconnected device has no driver
    assign line      = !(ds_dir || (pull && !disconnect) || stuck_low);
    assign data_byte = addr[7:0] ^ 8'h5A;
    assign sr_next   = {line, sr[7:1]};                 // LSB first

    always_ff @(posedge clk) begin
        line_q  <= line;
        low_cnt <= line ? 0 : low_cnt + 1;
        tmr     <= tmr + 1;
        if (reset) begin
            mode      <= m_idle;
            pull      <= 1'b0;
            phase     <= 3'd0;
            nbit      <= 3'd0;
            wr_bytes  <= 0;
            bad_cmds  <= 0;
            seen_addr <= '0;
            addr      <= '0;
        end else begin
            case (mode)
                m_idle: begin
                    tmr <= 1;
                    if (line && !line_q && low_cnt >= reset_min) begin  // end of reset pulse
                        mode  <= m_pres_wait;
                        phase <= 3'd0;
                        nbit  <= 3'd0;
                    end else if (!line && line_q) begin  // master opened a slot
                        mode <= (phase == 3'd4) ? m_rhold : m_wsample;
                        pull <= (phase == 3'd4) && !data_byte[nbit];
                    end
                end
                m_pres_wait: if (tmr == pres_wait) begin
                    pull <= 1'b1;
                    mode <= m_pres_low;
                    tmr  <= 1;
                end
                m_pres_low: if (tmr == pres_len) begin
                    pull <= 1'b0;
                    mode <= m_idle;
                end
                m_wsample: if (tmr == sample_at) begin
                    mode <= m_idle;
                    sr   <= sr_next;
                    nbit <= nbit + 3'd1;
                    if (nbit == 3'd7) begin  // byte complete
                        wr_bytes <= wr_bytes + 1;
                        phase    <= phase + 3'd1;
                        case (phase)
                            3'd0: if (sr_next != 8'hCC) bad_cmds <= bad_cmds + 1;
                            3'd1: if (sr_next != 8'hF0) bad_cmds <= bad_cmds + 1;
                            3'd2: addr[7:0] <= sr_next;
                            default: begin
                                addr[10:8] <= sr_next[2:0];
                                seen_addr  <= {sr_next[2:0], addr[7:0]};
                            end
                        endcase
                    end
                end
                default: if (tmr == hold_len) begin  // end of read slot answer
                    pull <= 1'b0;
                    mode <= m_idle;
                    nbit <= nbit + 3'd1;
                    if (nbit == 3'd7)
                        addr <= addr + 11'd1;
                end
            endcase
        end
    end

endmodule

// File: tb_ds2505_reader.sv
////////////////////////////////////////
// testbench for the DS2505 reader with a slave model
// reads, continue, no presence and stuck line cases
////////////////////////////////////////
`timescale 1ns/10ps

module tb_ds2505_reader;
    import ow_pkg::*;

    localparam int tb_clk_mhz  = 1;
    // one full read, worst case reset plus 4 written and 64 read bytes
    localparam int read_cycles = (reset_low_us + presence_timeout_us + recover_us
                                  + 4 * 8 * write_slot_us
                                  + block_bytes * 8 * read_slot_us) * tb_clk_mhz;
    localparam int timeout_cycles = 3 * read_cycles + 100_000;  // 3 reads, short cases, margin

    logic        clk, reset;
    logic [15:0] reg_raddr, reg_waddr;
    logic [31:0] reg_rdata, reg_wdata, ds_status;
    logic        reg_wen, ds_data_in, ds_data_out, ds_dir, ds_enable;
    logic        disconnect, stuck_low;
    int          wr_bytes, bad_cmds, bytes_before;
    logic [10:0] seen_addr, cur_addr;
    logic [31:0] lfsr, rnd;
    int          value_errs, rule_errs;
    int          cycles;

    ds2505_reader #(.clk_mhz(tb_clk_mhz)) dut0 (
        .clk, .reset, .reg_raddr, .reg_waddr, .reg_rdata, .reg_wdata, .ds_status,
        .reg_wen, .ds_data_in, .ds_data_out, .ds_dir, .ds_enable
    );

    tb_ds2505_model #(.clk_mhz(tb_clk_mhz)) dev0 (
        .clk, .reset, .ds_dir, .disconnect, .stuck_low, .line(ds_data_in),
        .wr_bytes, .bad_cmds, .seen_addr
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // concurrent checks
    assert property (@(posedge clk) disable iff (reset) ds_dir |-> !ds_data_out)
        else begin
            rule_errs++;
            $display("ERROR ds_data_out = %h while ds_dir = %h", ds_data_out, ds_dir);
        end

    // unused status bits stay 0, enable bit mirrors ds_enable
    assert property (@(posedge clk) disable iff (reset)
                     ds_status[7:4] == 4'h0 && ds_status[31:27] == 5'h0 &&
                     ds_status[3] == ds_enable)
        else begin
            rule_errs++;
            $display("ERROR ds_status = %h with ds_enable = %h", ds_status, ds_enable);
        end

    initial begin  // watchdog
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", timeout_cycles);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else begin
                value_errs++;
                $display("ERROR %s: got %h, expected %h", name, got, exp);
            end
    endtask

    // quadlet k of a block, first byte of four in 31:24
    function automatic logic [31:0] expected_quad(input logic [10:0] base, input int k);
        logic [31:0] q;
        logic [10:0] a;
        q = '0;
        for (int j = 0; j < 4; j++) begin
            a = base + 11'(4 * k + j);  // byte address wraps in 11 bits
            q = {q[23:0], a[7:0] ^ 8'h5A};
        end
        return q;
    endfunction

    task automatic write_ctl(input logic [1:0] code, input logic [10:0] addr);
        @(negedge clk);
        reg_waddr = reg_dsstat_addr;
        reg_wdata = {5'd0, addr, 14'd0, code};
        reg_wen   = 1'b1;
        @(negedge clk);
        reg_wen   = 1'b0;
        reg_wdata = '0;
    endtask

    task automatic run_read(input logic [1:0] code, input logic [10:0] addr);
        bytes_before = wr_bytes;
        write_ctl(code, addr);
        check_value("busy after write", ds_status[2], 1);
        while (ds_status[2])  // watchdog ends a hang
            @(negedge clk);
    endtask

    task automatic check_block(input logic [10:0] base);
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            reg_raddr = 16'(k);
            @(negedge clk);  // registered read port
            check_value($sformatf("reg_rdata[%0d]", k), reg_rdata, expected_quad(base, k));
        end
    endtask

    task automatic check_good_read(input logic [10:0] addr);
        check_value("status result", ds_status[1:0], rst_ok);
        check_value("status address", ds_status[26:16], addr);
        check_value("device bytes written", wr_bytes - bytes_before, 4);
        check_value("device start address", seen_addr, addr);
        assert (ds_status[15:8] < 8'(rise_timeout_us * tb_clk_mhz))
            else begin
                value_errs++;
                $display("rise time of a good read is not below the rise timeout");
            end
        check_block(addr);
    endtask

    ////////////////////////////////////////
    // stimulus
    initial begin
        reset      = 1'b1;
        reg_raddr  = '0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_wen    = 1'b0;
        disconnect = 1'b0;
        stuck_low  = 1'b0;
        value_errs = 0;
        rule_errs  = 0;
        lfsr       = 32'hc6ce_80bc;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_value("ds_status", ds_status, 0);  // idle after reset
        check_value("ds_dir", ds_dir, 0);
        check_value("ds_enable", ds_enable, 0);
        check_value("ds_data_out", ds_data_out, 1);

        write_ctl(ctl_enable, 11'd0);
        check_value("ds_enable", ds_enable, 1);
        check_value("status enable", ds_status[3], 1);
        check_value("busy on enable", ds_status[2], 0);
        write_ctl(ctl_disable, 11'd0);
        check_value("ds_enable", ds_enable, 0);
        check_value("status", ds_status[3:0], 0);

        random_bits(11, rnd);
        cur_addr = rnd[10:0];
        run_read(ctl_start, cur_addr);
        check_good_read(cur_addr);

        cur_addr = cur_addr + 11'd64;  // continue, next block mod 2048
        run_read(ctl_continue, 11'd0);
        check_good_read(cur_addr);

        random_bits(11, rnd);
        cur_addr = rnd[10:0];
        run_read(ctl_start, cur_addr);
        check_good_read(cur_addr);

        @(negedge clk);
        disconnect = 1'b1;  // nobody on the line
        run_read(ctl_start, 11'h155);
        check_value("status result", ds_status[1:0], rst_no_presence);
        check_value("device bytes written", wr_bytes - bytes_before, 0);
        disconnect = 1'b0;

        @(negedge clk);
        stuck_low = 1'b1;
        run_read(ctl_start, 11'h2AA);
        check_value("status result", ds_status[1:0], rst_no_rise);
        check_value("status rise", ds_status[15:8], 8'hFF);

        $display("errors: %0d value, %0d line/status rule, %0d device command",
                 value_errs, rule_errs, bad_cmds);
        if (value_errs + rule_errs + bad_cmds == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: src.f
ow_pkg.sv
ow_slot_timer.sv
ow_byte_engine.sv
ow_read_sequencer.sv
ow_mem_buffer.sv
ow_host_regs.sv
ds2505_reader.sv
tb_ds2505_model.sv
tb_ds2505_reader.sv

// File: Bender.yml
package:
  name: ds2505_reader

sources:
  - ow_pkg.sv
  - ow_slot_timer.sv
  - ow_byte_engine.sv
  - ow_read_sequencer.sv
  - ow_mem_buffer.sv
  - ow_host_regs.sv
  - ds2505_reader.sv
  - target: test
    files:
      - tb_ds2505_model.sv
      - tb_ds2505_reader.sv
